/* Bender.yml */
package:
  name: thumb_decode

sources:
  - rtl/thumb_decode_pkg.sv
  - rtl/cond_stage.sv
  - rtl/inst_decode.sv
  - rtl/ctrl_register.sv
  - rtl/thumb_decode.sv
  - target: simulation
    files:
      - sim/tb_thumb_decode.sv

/* rtl/cond_stage.sv */
`timescale 1ns/100ps

module cond_stage (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               inst_valid,
  input  logic [thumb_decode_pkg::INST_W-1:0] inst,
  input  logic [thumb_decode_pkg::PSR_W-1:0]  psr,
  output logic [thumb_decode_pkg::INST_W-1:0] inst_q,
  output logic                               inst_q_valid,
  output logic                               cond_pass
);

  import thumb_decode_pkg::*;

  logic [COND_W-1:0] cond;
  logic              z;
  logic              n;
  logic              c;
  logic              v;
  logic              cond_now;

  assign cond = inst[11:8];
  assign z    = psr[PSR_Z];
  assign n    = psr[PSR_N];
  assign c    = psr[PSR_C];
  assign v    = psr[PSR_V];

  always_comb
  begin
    case (cond)
      COND_EQ: cond_now = z;
      COND_NE: cond_now = !z;
      COND_CS: cond_now = c;
      COND_CC: cond_now = !c;
      COND_MI: cond_now = n;
      COND_PL: cond_now = !n;
      COND_VS: cond_now = v;
      COND_VC: cond_now = !v;
      COND_HI: cond_now = c && !z;
      COND_LS: cond_now = z || !c;
      COND_GE: cond_now = (n == v);
      COND_LT: cond_now = (n != v);
      COND_GT: cond_now = !z && (n == v);
      COND_LE: cond_now = z || (n != v);
      COND_AL: cond_now = 1'b1;
      default: cond_now = 1'b0; // never
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      inst_q_valid <= 1'b0;
    else
      inst_q_valid <= inst_valid;
  end

  // flags sampled with the instruction so later changes do not matter
  always_ff @(posedge clk)
  begin
    if (inst_valid)
    begin
      inst_q    <= inst;
      cond_pass <= cond_now;
    end
  end

endmodule

/* rtl/ctrl_register.sv */
`timescale 1ns/100ps

module ctrl_register (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       inst_q_valid,
  input  thumb_decode_pkg::alu_op_e  alu_sel_d,
  input  thumb_decode_pkg::sh_func_e sh_func_d,
  input  thumb_decode_pkg::src_sel_e rsrc_a_sel_d,
  input  thumb_decode_pkg::src_sel_e rsrc_b_sel_d,
  input  logic                       br_d,
  input  logic                       immed_sel_d,
  input  logic                       link_d,
  input  logic                       mem_inst_d,
  input  logic                       pc_offset_sel_d,
  input  logic                       sh_dir_d,
  input  logic                       shift_d,
  input  logic                       store_d,
  input  logic                       rdest_sel_d,
  input  logic                       wr_d,
  output thumb_decode_pkg::alu_op_e  alu_sel,
  output thumb_decode_pkg::sh_func_e sh_func,
  output thumb_decode_pkg::src_sel_e rsrc_a_sel,
  output thumb_decode_pkg::src_sel_e rsrc_b_sel,
  output logic                       br,
  output logic                       immed_sel,
  output logic                       link,
  output logic                       mem_inst,
  output logic                       pc_offset_sel,
  output logic                       sh_dir,
  output logic                       shift,
  output logic                       store,
  output logic                       rdest_sel,
  output logic                       wr,
  output logic                       ctrl_valid
);

  import thumb_decode_pkg::*;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      ctrl_valid <= 1'b0;
    else
      ctrl_valid <= inst_q_valid;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n || !inst_q_valid)
    begin
      alu_sel       <= ALU_NOP; // idle word so nothing fires
      sh_func       <= SH_LOGIC;
      rsrc_a_sel    <= SRC_00;
      rsrc_b_sel    <= SRC_00;
      br            <= 1'b0;
      immed_sel     <= 1'b0;
      link          <= 1'b0;
      mem_inst      <= 1'b0;
      pc_offset_sel <= 1'b0;
      sh_dir        <= 1'b0;
      shift         <= 1'b0;
      store         <= 1'b0;
      rdest_sel     <= 1'b0;
      wr            <= 1'b0;
    end
    else
    begin
      alu_sel       <= alu_sel_d;
      sh_func       <= sh_func_d;
      rsrc_a_sel    <= rsrc_a_sel_d;
      rsrc_b_sel    <= rsrc_b_sel_d;
      br            <= br_d;
      immed_sel     <= immed_sel_d;
      link          <= link_d;
      mem_inst      <= mem_inst_d;
      pc_offset_sel <= pc_offset_sel_d;
      sh_dir        <= sh_dir_d;
      shift         <= shift_d;
      store         <= store_d;
      rdest_sel     <= rdest_sel_d;
      wr            <= wr_d;
    end
  end

  a_alu_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(alu_sel))
    else $error("alu_sel has more than one operation selected");
  a_store_mem: assert property (@(posedge clk) disable iff (!rst_n) store |-> mem_inst)
    else $error("store without a memory instruction");
  a_link_br: assert property (@(posedge clk) disable iff (!rst_n) link |-> br)
    else $error("link without a branch");
  a_shift_nop: assert property (@(posedge clk) disable iff (!rst_n)
    shift |-> (alu_sel == ALU_NOP))
    else $error("shift issued with an active alu operation");

endmodule

/* rtl/inst_decode.sv */
`timescale 1ns/100ps

module inst_decode (
  input  logic [thumb_decode_pkg::INST_W-1:0] inst_q,
  input  logic                               cond_pass,
  output thumb_decode_pkg::alu_op_e          alu_sel,
  output thumb_decode_pkg::sh_func_e         sh_func,
  output thumb_decode_pkg::src_sel_e         rsrc_a_sel,
  output thumb_decode_pkg::src_sel_e         rsrc_b_sel,
  output logic                               br,
  output logic                               immed_sel,
  output logic                               link,
  output logic                               mem_inst,
  output logic                               pc_offset_sel,
  output logic                               sh_dir,
  output logic                               shift,
  output logic                               store,
  output logic                               rdest_sel,
  output logic                               wr
);

  import thumb_decode_pkg::*;

  logic [3:0] op4;
  logic [4:0] op5;
  logic [6:0] op7;
  logic [9:0] op10;
  logic       hit10; // one of the ten-bit register ops

  assign op4  = inst_q[15:12];
  assign op5  = inst_q[15:11];
  assign op7  = inst_q[15:9];
  assign op10 = inst_q[15:6];

  always_comb
  begin
    alu_sel       = ALU_NOP;
    sh_func       = SH_LOGIC;
    rsrc_a_sel    = SRC_00;
    rsrc_b_sel    = SRC_00;
    br            = 1'b0;
    immed_sel     = 1'b0;
    link          = 1'b0;
    mem_inst      = 1'b0;
    pc_offset_sel = 1'b0;
    sh_dir        = 1'b0;
    shift         = 1'b0;
    store         = 1'b0;
    rdest_sel     = 1'b0;
    wr            = 1'b0;
    hit10         = 1'b0;

    if (op4 == OP_BCOND)
    begin
      br = cond_pass; // resolved at capture
    end
    else
    begin
      case (op5)
        OP_ADDI, OP_SUBI, OP_CMPI, OP_MOVI:
        begin
          immed_sel  = 1'b1; // immed8
          rsrc_a_sel = SRC_11;
          rsrc_b_sel = SRC_11;
          rdest_sel  = 1'b1;
          wr         = (op5 != OP_CMPI);
          case (op5)
            OP_ADDI: alu_sel = ALU_ADD;
            OP_SUBI: alu_sel = ALU_SUB;
            OP_CMPI: alu_sel = ALU_CMP;
            default: alu_sel = ALU_MOV;
          endcase
        end
        OP_LSLI, OP_LSRI, OP_ASRI:
        begin
          shift      = 1'b1;
          immed_sel  = 1'b1; // shift amount
          rsrc_a_sel = SRC_01;
          rsrc_b_sel = SRC_01;
          wr         = 1'b1;
          sh_dir     = (op5 != OP_LSLI);
          if (op5 == OP_ASRI)
            sh_func = SH_ARITH;
        end
        OP_LDRI, OP_STRI:
        begin
          alu_sel    = ALU_ADD; // base plus offset
          immed_sel  = 1'b1;
          mem_inst   = 1'b1;
          rsrc_a_sel = SRC_01;
          rsrc_b_sel = SRC_01;
          wr         = (op5 == OP_LDRI);
          store      = (op5 == OP_STRI);
        end
        OP_BL, OP_BAL:
        begin
          immed_sel     = 1'b1;
          br            = 1'b1;
          pc_offset_sel = 1'b1;
          link          = (op5 == OP_BL);
        end
        default:
        begin
          case (op7)
            OP_ADD, OP_SUB, OP_LDR, OP_STR:
            begin
              rsrc_a_sel = SRC_10;
              rsrc_b_sel = SRC_01;
              if (op7 == OP_SUB)
                alu_sel = ALU_SUB;
              else
                alu_sel = ALU_ADD;
              wr       = (op7 != OP_STR);
              mem_inst = (op7 == OP_LDR) || (op7 == OP_STR);
              store    = (op7 == OP_STR);
            end
            default:
            begin
              hit10 = 1'b1;
              case (op10)
                OP_CMP: alu_sel = ALU_CMP;
                OP_AND: alu_sel = ALU_AND;
                OP_ORR: alu_sel = ALU_ORR;
                OP_EOR: alu_sel = ALU_EOR;
                OP_MOV:
                begin
                  alu_sel    = ALU_MOV;
                  rsrc_b_sel = SRC_01;
                end
                OP_LSL: shift = 1'b1;
                OP_LSR, OP_ASR, OP_ROR:
                begin
                  shift  = 1'b1;
                  sh_dir = 1'b1; // right
                  if (op10 == OP_ASR)
                    sh_func = SH_ARITH;
                  else if (op10 == OP_ROR)
                    sh_func = SH_ROT;
                end
                default: hit10 = 1'b0; // unknown code
              endcase
              if (hit10)
              begin
                rsrc_a_sel = SRC_01;
                wr         = (op10 != OP_CMP);
              end
            end
          endcase
        end
      endcase
    end
  end

endmodule

/* rtl/thumb_decode.sv */
`timescale 1ns/100ps

module thumb_decode (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               inst_valid,
  input  logic [thumb_decode_pkg::INST_W-1:0] inst,
  input  logic [thumb_decode_pkg::PSR_W-1:0]  psr,
  output thumb_decode_pkg::alu_op_e          alu_sel,
  output thumb_decode_pkg::sh_func_e         sh_func,
  output thumb_decode_pkg::src_sel_e         rsrc_a_sel,
  output thumb_decode_pkg::src_sel_e         rsrc_b_sel,
  output logic                               br,
  output logic                               immed_sel,
  output logic                               link,
  output logic                               mem_inst,
  output logic                               pc_offset_sel,
  output logic                               sh_dir,
  output logic                               shift,
  output logic                               store,
  output logic                               rdest_sel,
  output logic                               wr,
  output logic                               ctrl_valid
);

  import thumb_decode_pkg::*;

  logic [INST_W-1:0] inst_q;
  logic              inst_q_valid;
  logic              cond_pass;
  alu_op_e           alu_sel_d;
  sh_func_e          sh_func_d;
  src_sel_e          rsrc_a_sel_d;
  src_sel_e          rsrc_b_sel_d;
  logic              br_d;
  logic              immed_sel_d;
  logic              link_d;
  logic              mem_inst_d;
  logic              pc_offset_sel_d;
  logic              sh_dir_d;
  logic              shift_d;
  logic              store_d;
  logic              rdest_sel_d;
  logic              wr_d;

  cond_stage u_cond_stage (
    .clk          (clk),
    .rst_n        (rst_n),
    .inst_valid   (inst_valid),
    .inst         (inst),
    .psr          (psr),
    .inst_q       (inst_q),
    .inst_q_valid (inst_q_valid),
    .cond_pass    (cond_pass)
  );

  inst_decode u_inst_decode (
    .inst_q        (inst_q),
    .cond_pass     (cond_pass),
    .alu_sel       (alu_sel_d),
    .sh_func       (sh_func_d),
    .rsrc_a_sel    (rsrc_a_sel_d),
    .rsrc_b_sel    (rsrc_b_sel_d),
    .br            (br_d),
    .immed_sel     (immed_sel_d),
    .link          (link_d),
    .mem_inst      (mem_inst_d),
    .pc_offset_sel (pc_offset_sel_d),
    .sh_dir        (sh_dir_d),
    .shift         (shift_d),
    .store         (store_d),
    .rdest_sel     (rdest_sel_d),
    .wr            (wr_d)
  );

  ctrl_register u_ctrl_register (
    .clk             (clk),
    .rst_n           (rst_n),
    .inst_q_valid    (inst_q_valid),
    .alu_sel_d       (alu_sel_d),
    .sh_func_d       (sh_func_d),
    .rsrc_a_sel_d    (rsrc_a_sel_d),
    .rsrc_b_sel_d    (rsrc_b_sel_d),
    .br_d            (br_d),
    .immed_sel_d     (immed_sel_d),
    .link_d          (link_d),
    .mem_inst_d      (mem_inst_d),
    .pc_offset_sel_d (pc_offset_sel_d),
    .sh_dir_d        (sh_dir_d),
    .shift_d         (shift_d),
    .store_d         (store_d),
    .rdest_sel_d     (rdest_sel_d),
    .wr_d            (wr_d),
    .alu_sel         (alu_sel),
    .sh_func         (sh_func),
    .rsrc_a_sel      (rsrc_a_sel),
    .rsrc_b_sel      (rsrc_b_sel),
    .br              (br),
    .immed_sel       (immed_sel),
    .link            (link),
    .mem_inst        (mem_inst),
    .pc_offset_sel   (pc_offset_sel),
    .sh_dir          (sh_dir),
    .shift           (shift),
    .store           (store),
    .rdest_sel       (rdest_sel),
    .wr              (wr),
    .ctrl_valid      (ctrl_valid)
  );

endmodule

/* rtl/thumb_decode_pkg.sv */
package thumb_decode_pkg;

  localparam int INST_W = 16;
  localparam int PSR_W  = 4;
  localparam int COND_W = 4;

  // flag positions in psr
  localparam int PSR_Z = 3;
  localparam int PSR_N = 2;
  localparam int PSR_C = 1;
  localparam int PSR_V = 0;

  // ten-bit opcodes in inst[15:6]
  localparam logic [9:0] OP_CMP = 10'b0100001010;
  localparam logic [9:0] OP_AND = 10'b0100000000;
  localparam logic [9:0] OP_ORR = 10'b0100001100;
  localparam logic [9:0] OP_EOR = 10'b0100000001;
  localparam logic [9:0] OP_MOV = 10'b0001110000;
  localparam logic [9:0] OP_LSL = 10'b0100000010;
  localparam logic [9:0] OP_LSR = 10'b0100000011;
  localparam logic [9:0] OP_ASR = 10'b0100000100;
  localparam logic [9:0] OP_ROR = 10'b0100000111;

  // seven-bit opcodes in inst[15:9]
  localparam logic [6:0] OP_ADD = 7'b0001100;
  localparam logic [6:0] OP_SUB = 7'b0001101;
  localparam logic [6:0] OP_LDR = 7'b0101100;
  localparam logic [6:0] OP_STR = 7'b0101000;

  // five-bit opcodes in inst[15:11]
  localparam logic [4:0] OP_ADDI = 5'b00110;
  localparam logic [4:0] OP_SUBI = 5'b00111;
  localparam logic [4:0] OP_CMPI = 5'b00101;
  localparam logic [4:0] OP_MOVI = 5'b00100;
  localparam logic [4:0] OP_LSLI = 5'b00000;
  localparam logic [4:0] OP_LSRI = 5'b00001;
  localparam logic [4:0] OP_ASRI = 5'b00010;
  localparam logic [4:0] OP_LDRI = 5'b01101;
  localparam logic [4:0] OP_STRI = 5'b01100;
  localparam logic [4:0] OP_BL   = 5'b11111;
  localparam logic [4:0] OP_BAL  = 5'b11100;

  localparam logic [3:0] OP_BCOND = 4'b1101; // conditional branch in inst[15:12]

  // code 15 means never and has no name here
  typedef enum logic [COND_W-1:0] {
    COND_EQ, COND_NE, COND_CS, COND_CC,
    COND_MI, COND_PL, COND_VS, COND_VC,
    COND_HI, COND_LS, COND_GE, COND_LT,
    COND_GT, COND_LE, COND_AL
  } cond_e;

  typedef enum logic [6:0] {
    ALU_NOP = 7'b0000000,
    ALU_ADD = 7'b1000000,
    ALU_SUB = 7'b0100000,
    ALU_CMP = 7'b0010000,
    ALU_AND = 7'b0001000,
    ALU_ORR = 7'b0000100,
    ALU_EOR = 7'b0000010,
    ALU_MOV = 7'b0000001
  } alu_op_e;

  typedef enum logic [2:0] {
    SH_LOGIC = 3'b100,
    SH_ARITH = 3'b010,
    SH_ROT   = 3'b001
  } sh_func_e;

  typedef enum logic [1:0] {
    SRC_00 = 2'b00,
    SRC_01 = 2'b01,
    SRC_10 = 2'b10,
    SRC_11 = 2'b11
  } src_sel_e;

endpackage

/* sim/tb_thumb_decode.sv */
`timescale 1ns/100ps

module tb_thumb_decode;

  import thumb_decode_pkg::*;

  localparam int N_SWEEP = 1024; // every value of inst[15:6]
  localparam int N_COND  = 256;  // 16 codes by 16 flag values
  localparam int N_RAND  = 300;
  localparam int STIM_CYCLES = 2 + N_SWEEP + N_COND + 3 * N_RAND + 16;
  localparam int WATCHDOG_NS = (STIM_CYCLES + 20) * 100;
  localparam logic [24:0] IDLE_WORD = {1'b0, ALU_NOP, SH_LOGIC, SRC_00, SRC_00, 10'b0};

  logic              clk;
  logic              rst_n;
  logic              inst_valid;
  logic [INST_W-1:0] inst;
  logic [PSR_W-1:0]  psr;
  alu_op_e           alu_sel;
  sh_func_e          sh_func;
  src_sel_e          rsrc_a_sel;
  src_sel_e          rsrc_b_sel;
  logic              br;
  logic              immed_sel;
  logic              link;
  logic              mem_inst;
  logic              pc_offset_sel;
  logic              sh_dir;
  logic              shift;
  logic              store;
  logic              rdest_sel;
  logic              wr;
  logic              ctrl_valid;
  logic [24:0]       dut_word;
  logic [24:0]       exp_q1 = 25'b0;
  logic [24:0]       exp_q2 = 25'b0;
  int                mismatch_count = 0;
  int                other_count = 0;

  thumb_decode dut (.*);

  assign dut_word = {ctrl_valid, alu_sel, sh_func, rsrc_a_sel, rsrc_b_sel, br, immed_sel,
                     link, mem_inst, pc_offset_sel, sh_dir, shift, store, rdest_sel, wr};

  function automatic logic cond_ref(input logic [3:0] code, input logic [3:0] f);
    logic z, n, c, v;
    z = f[3];
    n = f[2];
    c = f[1];
    v = f[0];
    case (code)
      4'd0:    return z;
      4'd1:    return ~z;
      4'd2:    return c;
      4'd3:    return ~c;
      4'd4:    return n;
      4'd5:    return ~n;
      4'd6:    return v;
      4'd7:    return ~v;
      4'd8:    return c & ~z;
      4'd9:    return z | ~c;
      4'd10:   return n ~^ v;
      4'd11:   return n ^ v;
      4'd12:   return ~z & (n ~^ v);
      4'd13:   return z | (n ^ v);
      4'd14:   return 1'b1;
      default: return 1'b0; // never
    endcase
  endfunction

  function automatic logic [23:0] decode_ref(input logic [15:0] i, input logic pass);
    logic [4:0] op5;
    logic [6:0] op7;
    logic [9:0] op10;
    logic [6:0] alu;
    logic [2:0] sh;
    logic [1:0] a, b;
    logic bre, imm, lnk, mem, pc, dir, shf, st, rd, w;
    op5 = i[15:11];
    op7 = i[15:9];
    op10 = i[15:6];
    alu = ALU_NOP;
    sh = SH_LOGIC;
    {a, b} = 4'b0;
    {bre, imm, lnk, mem, pc, dir, shf, st, rd, w} = 10'b0;
    if (i[15:12] == OP_BCOND)
      bre = pass;
    else if (op5 inside {OP_ADDI, OP_SUBI, OP_CMPI, OP_MOVI})
    begin
      alu = (op5 == OP_ADDI) ? ALU_ADD : (op5 == OP_SUBI) ? ALU_SUB :
            (op5 == OP_CMPI) ? ALU_CMP : ALU_MOV;
      imm = 1'b1;
      {a, b} = 4'b1111;
      rd = 1'b1;
      w = (op5 != OP_CMPI);
    end
    else if (op5 inside {OP_LSLI, OP_LSRI, OP_ASRI})
    begin
      {shf, imm, w} = 3'b111;
      {a, b} = 4'b0101;
      dir = (op5 != OP_LSLI);
      sh = (op5 == OP_ASRI) ? SH_ARITH : SH_LOGIC;
    end
    else if (op5 inside {OP_LDRI, OP_STRI})
    begin
      alu = ALU_ADD;
      {imm, mem} = 2'b11;
      {a, b} = 4'b0101;
      w = (op5 == OP_LDRI);
      st = (op5 == OP_STRI);
    end
    else if (op5 inside {OP_BL, OP_BAL})
    begin
      {imm, bre, pc} = 3'b111;
      lnk = (op5 == OP_BL);
    end
    else if (op7 inside {OP_ADD, OP_SUB, OP_LDR, OP_STR})
    begin
      {a, b} = 4'b1001;
      alu = (op7 == OP_SUB) ? ALU_SUB : ALU_ADD;
      w = (op7 != OP_STR);
      mem = (op7 inside {OP_LDR, OP_STR});
      st = (op7 == OP_STR);
    end
    else if (op10 inside {OP_CMP, OP_AND, OP_ORR, OP_EOR, OP_MOV,
                          OP_LSL, OP_LSR, OP_ASR, OP_ROR})
    begin
      a = 2'b01;
      b = (op10 == OP_MOV) ? 2'b01 : 2'b00;
      w = (op10 != OP_CMP);
      if (op10 == OP_CMP) alu = ALU_CMP;
      if (op10 == OP_AND) alu = ALU_AND;
      if (op10 == OP_ORR) alu = ALU_ORR;
      if (op10 == OP_EOR) alu = ALU_EOR;
      if (op10 == OP_MOV) alu = ALU_MOV;
      shf = (op10 inside {OP_LSL, OP_LSR, OP_ASR, OP_ROR});
      dir = (op10 inside {OP_LSR, OP_ASR, OP_ROR});
      sh = (op10 == OP_ASR) ? SH_ARITH : (op10 == OP_ROR) ? SH_ROT : SH_LOGIC;
    end
    return {alu, sh, a, b, bre, imm, lnk, mem, pc, dir, shf, st, rd, w};
  endfunction

  task automatic field_diff(input string name, input logic [6:0] e, input logic [6:0] a);
    if (e !== a)
    begin
      mismatch_count++;
      $display("mismatch at %0t: %s expected %0h actual %0h", $time, name, e, a);
    end
  endtask

  task automatic show_diffs(input logic [24:0] e, input logic [24:0] a);
    field_diff("ctrl_valid", e[24], a[24]);
    field_diff("alu_sel", e[23:17], a[23:17]);
    field_diff("sh_func", e[16:14], a[16:14]);
    field_diff("rsrc_a_sel", e[13:12], a[13:12]);
    field_diff("rsrc_b_sel", e[11:10], a[11:10]);
    field_diff("br", e[9], a[9]);
    field_diff("immed_sel", e[8], a[8]);
    field_diff("link", e[7], a[7]);
    field_diff("mem_inst", e[6], a[6]);
    field_diff("pc_offset_sel", e[5], a[5]);
    field_diff("sh_dir", e[4], a[4]);
    field_diff("shift", e[3], a[3]);
    field_diff("store", e[2], a[2]);
    field_diff("rdest_sel", e[1], a[1]);
    field_diff("wr", e[0], a[0]);
  endtask

  // expected word lines up with the 2 cycle latency
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      exp_q1 <= IDLE_WORD;
      exp_q2 <= IDLE_WORD;
    end
    else
    begin
      exp_q1 <= inst_valid ? {1'b1, decode_ref(inst, cond_ref(inst[11:8], psr))} : IDLE_WORD;
      exp_q2 <= exp_q1;
    end
  end

  a_word: assert property (@(posedge clk) disable iff (!rst_n) dut_word == exp_q2)
    else show_diffs($sampled(exp_q2), $sampled(dut_word));
  a_latency: assert property (@(posedge clk) disable iff (!rst_n) inst_valid |-> ##2 ctrl_valid)
    else
    begin
      other_count++;
      $display("at %0t ctrl_valid did not follow inst_valid after 2 cycles", $time);
    end
  a_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !ctrl_valid |-> (dut_word[23:0] == IDLE_WORD[23:0]))
    else
    begin
      other_count++;
      $display("at %0t a control output is active while ctrl_valid is low", $time);
    end

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic drive_strobe(input logic [15:0] i, input logic [3:0] f);
    @(posedge clk);
    #1;
    inst_valid = 1'b1;
    inst = i;
    psr = f;
  endtask

  task automatic drive_idle(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #1;
      inst_valid = 1'b0;
      inst = 16'($urandom); // garbage on the bus when idle
      psr = 4'($urandom);
    end
  endtask

  initial
  begin
    logic [9:0] top;
    logic [3:0] code;
    logic [3:0] flags;
    void'($urandom(32'h3130cfb3));
    rst_n = 1'b0;
    inst_valid = 1'b0;
    inst = '0;
    psr = '0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    drive_idle(3);
    for (int k = 0; k < N_SWEEP; k++)
    begin
      top = k;
      drive_strobe({top, 6'($urandom)}, 4'($urandom));
    end
    drive_idle(3);
    for (int k = 0; k < N_COND; k++)
    begin
      code = k / 16;
      flags = k % 16;
      drive_strobe({OP_BCOND, code, 8'($urandom)}, flags);
    end
    drive_idle(3);
    for (int k = 0; k < N_RAND; k++)
    begin
      drive_strobe(16'($urandom), 4'($urandom));
      drive_idle($urandom % 3); // 0 keeps strobes back to back
    end
    drive_idle(4);
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count + other_count == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the stimulus finished");
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* thumb_decode.f */
rtl/thumb_decode_pkg.sv
rtl/cond_stage.sv
rtl/inst_decode.sv
rtl/ctrl_register.sv
rtl/thumb_decode.sv
sim/tb_thumb_decode.sv
